/* Bender.yml */
package:
  name: compact_fetch

sources:
  - files:
      - verilog/rvcPkg.sv
      - verilog/compactInstructionsUnit.sv
      - verilog/programMemory.sv
      - verilog/memoryArbiter.sv
      - verilog/fetchUnit.sv
      - verilog/compactFetchTop.sv
  - target: test
    files:
      - test/compactFetch_assert.sv
      - test/compactFetchTb.sv

/* files.f */
verilog/rvcPkg.sv
verilog/compactInstructionsUnit.sv
verilog/programMemory.sv
verilog/memoryArbiter.sv
verilog/fetchUnit.sv
verilog/compactFetchTop.sv
test/compactFetch_assert.sv
test/compactFetchTb.sv

/* test/compactFetchTb.sv */
module compactFetchTb import rvcPkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumInstr = 120;

  typedef struct {
    logic [31:0] pc;
    logic [31:0] instr;
    logic        compressed;
    logic        ill;
    logic        ign;
    logic        ni;
  } expectEntry;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 run;
  logic                 stall;
  logic                 loadWrite;
  logic [AddrWidth-1:0] loadAddr;
  logic [31:0]          loadData;
  logic [31:0]          instruction;
  logic [31:0]          instrPc;
  logic                 instrValid;
  logic                 isCompressed;
  logic                 illegal;
  logic                 ignored;
  logic                 notImplemented;

  logic [31:0] rngState = 32'd92587;
  expectEntry  expected[$];
  logic [15:0] halves[$];
  logic [31:0] image[MemWords];
  int          progWords;
  int          checkedCount = 0;
  int          pulseCount = 0;
  logic        lastStall = 1'b0;

  compactFetchTop dut_i (.*);

  always #5 clk = ~clk;

  function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1103515245 + 32'd12345;
    return rngState ^ (rngState >> 16);
  endfunction

  function automatic logic [31:0] fillWord(int addr);
    logic [7:0] a;
    a = addr[7:0];
    return {a, ~a, a ^ 8'h5a, a[5:0], 2'b11}; // Full-width filler
  endfunction

  function automatic logic [31:0] iType(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OpReg};
  endfunction

  function automatic void expectedExpansion(input logic [31:0] target,
                                            output logic [31:0] word,
                                            output logic ill, output logic ign,
                                            output logic ni);
    logic [15:0] p;
    logic [4:0]  rdW;
    logic [4:0]  rdN;
    logic [4:0]  rs2N;
    logic [11:0] ci;
    logic [11:0] lwOff;
    logic [12:0] bOff;
    logic [20:0] jOff;
    p     = target[15:0];
    rdW   = p[11:7];
    rdN   = {2'b01, p[9:7]};
    rs2N  = {2'b01, p[4:2]};
    ci    = {{7{p[12]}}, p[6:2]};
    lwOff = {5'd0, p[5], p[12:10], p[6], 2'b00};
    bOff  = {{5{p[12]}}, p[6:5], p[2], p[11:10], p[4:3], 1'b0};
    jOff  = {{10{p[12]}}, p[8], p[10:9], p[6], p[7], p[2], p[11], p[5:3], 1'b0};
    word  = '0;
    ill   = 1'b0;
    ign   = 1'b0;
    ni    = 1'b0;
    if (p[1:0] == 2'b11) begin
      word = target;
    end else begin
      case ({p[1:0], p[15:13]})
        5'b00_000: ill = (p == 16'h0000);
        5'b00_010: word = iType(lwOff, rdN, 3'b010, rs2N, OpLoad);
        5'b00_100: ill = 1'b1;
        5'b00_110: word = {lwOff[11:5], rs2N, rdN, 3'b010, lwOff[4:0], OpStore};
        5'b01_000: word = iType(ci, rdW, 3'b000, rdW, OpImm);
        5'b01_010: word = iType(ci, 5'd0, 3'b000, rdW, OpImm);
        5'b01_011: word = {{15{p[12]}}, p[6:2], rdW, OpLui};
        5'b01_100: begin
          if (p[11:10] == 2'b10) begin
            word = iType(ci, rdN, 3'b111, rdN, OpImm);
          end else if (p[11:10] == 2'b11 && !p[12]) begin
            case (p[6:5])
              2'b00: word = rType(7'b0100000, rs2N, rdN, 3'b000, rdN);
              2'b01: word = rType(7'b0, rs2N, rdN, 3'b100, rdN);
              2'b10: word = rType(7'b0, rs2N, rdN, 3'b110, rdN);
              default: word = rType(7'b0, rs2N, rdN, 3'b111, rdN);
            endcase
          end
        end
        5'b01_101: word = {jOff[20], jOff[10:1], jOff[11], jOff[19:12], 5'd0, OpJal};
        5'b01_110: word = {bOff[12], bOff[10:5], 5'd0, rdN, 3'b000, bOff[4:1], bOff[11],
                           OpBranch};
        5'b10_000, 5'b10_010, 5'b10_110: ni = 1'b1;
        5'b10_100: begin
          if (p[12] && p[6:2] != 5'd0) begin
            word = rType(7'b0, p[6:2], rdW, 3'b000, rdW);
          end else begin
            ni = 1'b1;
          end
        end
        default: ign = 1'b1; // FP and wider forms in this test set
      endcase
    end
  endfunction

  function automatic logic [15:0] makeParcel(logic [31:0] r);
    logic [15:0] fixed[7];
    fixed = '{16'h0000, 16'h8000, 16'h2000, 16'h2002, 16'h0086, 16'h8082, 16'hc006};
    case (r[31:24] % 12)
      0: return {3'b000, r[12:2], 2'b01}; // C.ADDI
      1: return {3'b010, r[12:2], 2'b01}; // C.LI
      2: return {3'b011, r[12], r[11:8], 1'b1, r[6:2], 2'b01}; // C.LUI with rd never sp
      3: return {3'b100, r[12], 2'b10, r[9:2], 2'b01}; // C.ANDI
      4: return {3'b100, 1'b0, 2'b11, r[9:2], 2'b01}; // C.SUB/XOR/OR/AND
      5: return {3'b010, r[12:2], 2'b00}; // C.LW
      6: return {3'b110, r[12:2], 2'b00}; // C.SW
      7: return {3'b100, 1'b1, r[11:7], r[6:3], 1'b1, 2'b10}; // C.ADD
      8: return {3'b110, r[12:2], 2'b01}; // C.BEQZ
      9: return {3'b101, r[12:2], 2'b01}; // C.J
      default: return fixed[r[15:13] % 7];
    endcase
  endfunction

  task automatic failRun(string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkWord(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      failRun("wrong word on the fetch output");
    end
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      failRun("wrong flag on the fetch output");
    end
  endtask

  task automatic buildProgram();
    expectEntry  e;
    logic [31:0] r;
    logic [31:0] w;
    logic [31:0] pc;
    pc = 0;
    for (int i = 0; i < NumInstr; i++) begin
      r = nextRandom();
      if (r[1:0] == 2'b00) begin
        w = nextRandom() | 32'h0000_0003;
        halves.push_back(w[15:0]);
        halves.push_back(w[31:16]);
        e.compressed = 1'b0;
      end else begin
        w = {16'h0000, makeParcel(r)};
        halves.push_back(w[15:0]);
        e.compressed = 1'b1;
      end
      e.pc = pc;
      expectedExpansion(w, e.instr, e.ill, e.ign, e.ni);
      expected.push_back(e);
      pc += e.compressed ? 2 : 4;
    end
    if (halves.size() % 2) begin
      halves.push_back(16'h0001);
    end
    progWords = halves.size() / 2;
    for (int a = 0; a < MemWords; a++) begin
      image[a] = (a < progWords) ? {halves[2*a+1], halves[2*a]} : fillWord(a);
    end
  endtask

  // New pulse only when the preceding cycle was not stalled
  always @(posedge clk) begin
    expectEntry e;
    if (!rst && instrValid && !lastStall) begin
      pulseCount++;
      if (expected.size() > 0) begin
        e = expected.pop_front();
        checkWord("instrPc", instrPc, e.pc);
        checkWord("instruction", instruction, e.instr);
        checkFlag("isCompressed", isCompressed, e.compressed);
        checkFlag("illegal", illegal, e.ill);
        checkFlag("ignored", ignored, e.ign);
        checkFlag("notImplemented", notImplemented, e.ni);
        checkedCount++;
      end
    end
    lastStall = stall;
  end

  initial begin
    int          cycles;
    logic [31:0] r;
    rst       = 1'b1;
    run       = 1'b0;
    stall     = 1'b0;
    loadWrite = 1'b0;
    loadAddr  = '0;
    loadData  = '0;
    buildProgram();
    repeat (16) @(negedge clk);
    rst = 1'b0;
    for (int a = 0; a < MemWords; a++) begin
      @(negedge clk);
      loadWrite = 1'b1;
      loadAddr  = a[AddrWidth-1:0];
      loadData  = image[a];
    end
    @(negedge clk);
    loadWrite = 1'b0;
    repeat (20) @(negedge clk);
    if (pulseCount != 0) begin
      failRun("instrValid pulsed while run was low");
    end
    run    = 1'b1;
    cycles = 0;
    while (checkedCount < NumInstr) begin
      @(negedge clk);
      r         = nextRandom();
      stall     = (r[3:0] < 4'd3);
      loadWrite = (r[7:4] < 4'd2); // Writes above the program with the same contents
      loadAddr  = AddrWidth'(progWords + r[15:8] % (MemWords - progWords));
      loadData  = fillWord(progWords + r[15:8] % (MemWords - progWords));
      cycles++;
      if (cycles > 5000) begin
        failRun("timed out waiting for all instructions to be fetched");
      end
    end
    @(negedge clk);
    stall     = 1'b0;
    loadWrite = 1'b0;
    run       = 1'b0;
    repeat (4) @(negedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* test/compactFetch_assert.sv */
module compactFetchAssert (
  input logic        clk,
  input logic        rst,
  input logic        run,
  input logic        stall,
  input logic        loadWrite,
  input logic        fetchGrant,
  input logic        fetchDataValid,
  input logic        instrValid,
  input logic [31:0] instrPc,
  input logic [31:0] targetInstruction,
  input logic        isCompressed
);
  timeunit 1ns;
  timeprecision 1ps;

  grantYieldsToLoader: assert property (@(posedge clk) disable iff (rst)
    loadWrite |-> !fetchGrant) else $error("fetch granted during a loader write");

  dataFollowsGrant: assert property (@(posedge clk) disable iff (rst)
    fetchGrant |=> fetchDataValid) else $error("read data valid missing after grant");

  dataOnlyAfterGrant: assert property (@(posedge clk) disable iff (rst)
    fetchDataValid |-> $past(fetchGrant)) else $error("read data valid without a grant");

  quietInReset: assert property (@(posedge clk)
    rst |=> !instrValid) else $error("instrValid high during reset");

  quietWhenIdle: assert property (@(posedge clk) disable iff (rst)
    !run && !stall |=> !instrValid) else $error("instrValid high while run is low");

  // Stall freezes every fetch output
  holdOnStall: assert property (@(posedge clk) disable iff (rst)
    stall |=> $stable(instrValid) && $stable(instrPc) && $stable(targetInstruction)
      && $stable(isCompressed)) else $error("fetch outputs moved during stall");

endmodule

bind fetchUnit compactFetchAssert fetchChecks_i (
  .clk              (clk),
  .rst              (rst),
  .run              (run),
  .stall            (stall),
  .loadWrite        (1'b0),
  .fetchGrant       (fetchGrant),
  .fetchDataValid   (fetchDataValid),
  .instrValid       (instrValid),
  .instrPc          (instrPc),
  .targetInstruction(targetInstruction),
  .isCompressed     (isCompressed)
);

bind memoryArbiter compactFetchAssert arbiterChecks_i (
  .clk              (clk),
  .rst              (rst),
  .run              (1'b1),
  .stall            (1'b0),
  .loadWrite        (loadWrite),
  .fetchGrant       (fetchGrant),
  .fetchDataValid   (fetchDataValid),
  .instrValid       (1'b0),
  .instrPc          (32'd0),
  .targetInstruction(32'd0),
  .isCompressed     (1'b0)
);

/* verilog/compactFetchTop.sv */
module compactFetchTop import rvcPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic                 stall,
  input  logic                 loadWrite,
  input  logic [AddrWidth-1:0] loadAddr,
  input  logic [31:0]          loadData,
  output logic [31:0]          instruction,
  output logic [31:0]          instrPc,
  output logic                 instrValid,
  output logic                 isCompressed,
  output logic                 illegal,
  output logic                 ignored,
  output logic                 notImplemented
);

  logic                 fetchRead;
  logic [AddrWidth-1:0] fetchAddr;
  logic                 fetchGrant;
  logic                 fetchDataValid;
  logic                 memEnable;
  logic                 memWrite;
  logic [AddrWidth-1:0] memAddr;
  logic [31:0]          memWriteData;
  logic [31:0]          memReadData;
  logic [31:0]          targetInstruction;

  memoryArbiter arbiter_i (
    .clk           (clk),
    .rst           (rst),
    .loadWrite     (loadWrite),
    .loadAddr      (loadAddr),
    .loadData      (loadData),
    .fetchRead     (fetchRead),
    .fetchAddr     (fetchAddr),
    .fetchGrant    (fetchGrant),
    .fetchDataValid(fetchDataValid),
    .memEnable     (memEnable),
    .memWrite      (memWrite),
    .memAddr       (memAddr),
    .memWriteData  (memWriteData)
  );

  programMemory memory_i (
    .clk         (clk),
    .memEnable   (memEnable),
    .memWrite    (memWrite),
    .memAddr     (memAddr),
    .memWriteData(memWriteData),
    .memReadData (memReadData)
  );

  fetchUnit fetch_i (
    .clk              (clk),
    .rst              (rst),
    .run              (run),
    .stall            (stall),
    .fetchRead        (fetchRead),
    .fetchAddr        (fetchAddr),
    .fetchGrant       (fetchGrant),
    .fetchDataValid   (fetchDataValid),
    .fetchData        (memReadData),
    .targetInstruction(targetInstruction),
    .instrValid       (instrValid),
    .instrPc          (instrPc),
    .isCompressed     (isCompressed)
  );

  compactInstructionsUnit expander_i (
    .targetInstruction(targetInstruction),
    .resultInstruction(instruction),
    .illegal          (illegal),
    .ignored          (ignored),
    .notImplemented   (notImplemented)
  );

endmodule

/* verilog/compactInstructionsUnit.sv */
module compactInstructionsUnit import rvcPkg::*; (
  input  logic [31:0] targetInstruction,
  output logic [31:0] resultInstruction,
  output logic        illegal,
  output logic        ignored,
  output logic        notImplemented
);

  compactParcel parcel;

  logic [4:0]  rdNarrow;
  logic [4:0]  rs2Narrow;
  logic [11:0] immAddi4spn;
  logic [11:0] immWord;
  logic [11:0] immCi;
  logic [11:0] immJ;
  logic [11:0] immSp;
  logic [8:0]  immB;
  logic [19:0] immLui;
  logic [31:0] expanded;

  assign parcel = targetInstruction[15:0];

  assign rdNarrow  = {2'b01, parcel.narrow.rsLeft}; // x8..x15
  assign rs2Narrow = {2'b01, parcel.narrow.rsRight};

  // Immediates scrambled as the compressed formats place them
  assign immAddi4spn = {2'b00, parcel[10:7], parcel[12:11], parcel[5], parcel[6], 2'b00};
  assign immWord     = {5'b00000, parcel[5], parcel.narrow.immHigh, parcel[6], 2'b00};
  assign immCi       = {{7{parcel.wide.func4}}, parcel.wide.rsRight};
  assign immJ        = {parcel[12], parcel[8], parcel[10:9], parcel[6], parcel[7],
                        parcel[2], parcel[11], parcel[5:3], 1'b0};
  assign immB        = {parcel[12], parcel[6:5], parcel[2], parcel[11:10], parcel[4:3], 1'b0};
  assign immSp       = {{3{parcel[12]}}, parcel[4:3], parcel[5], parcel[2], parcel[6], 4'b0000};
  assign immLui      = {{15{parcel[12]}}, parcel.wide.rsRight};

  assign resultInstruction = (parcel.wide.op == FullOp) ? targetInstruction : expanded;

  always_comb begin
    expanded       = '0;
    illegal        = 1'b0;
    ignored        = 1'b0;
    notImplemented = 1'b0;

    case (parcel.wide.op)
      2'b00: begin
        case (parcel.wide.func3)
          3'b000: begin
            if (parcel == '0) begin
              illegal = 1'b1; // All-zero parcel
            end else begin // C.ADDI4SPN
              expanded = {immAddi4spn, SpReg, 3'b000, rs2Narrow, OpImm};
            end
          end
          3'b010: begin // C.LW
            expanded = {immWord, rdNarrow, 3'b010, rs2Narrow, OpLoad};
          end
          3'b100: illegal = 1'b1; // Reserved
          3'b110: begin // C.SW
            expanded = {immWord[11:5], rs2Narrow, rdNarrow, 3'b010, immWord[4:0], OpStore};
          end
          default: ignored = 1'b1; // FP and RV64/128 loads and stores
        endcase
      end

      2'b01: begin
        case (parcel.wide.func3)
          3'b000: begin // C.ADDI
            expanded = {immCi, parcel.wide.rsLeft, 3'b000, parcel.wide.rsLeft, OpImm};
          end
          3'b001: begin // C.JAL
            expanded = {immJ[11], immJ[10:1], immJ[11], {8{immJ[11]}}, RaReg, OpJal};
          end
          3'b010: begin // C.LI
            expanded = {immCi, ZeroReg, 3'b000, parcel.wide.rsLeft, OpImm};
          end
          3'b011: begin
            if (parcel.wide.rsLeft == SpReg) begin // C.ADDI16SP
              expanded = {immSp, SpReg, 3'b000, SpReg, OpImm};
            end else begin // C.LUI
              expanded = {immLui, parcel.wide.rsLeft, OpLui};
            end
          end
          3'b100: begin
            case (parcel.narrow.immHigh[1:0])
              2'b00: begin // C.SRLI
                expanded = {7'b0000000, parcel.wide.rsRight, rdNarrow, 3'b101, rdNarrow, OpImm};
              end
              2'b01: begin // C.SRAI
                expanded = {7'b0100000, parcel.wide.rsRight, rdNarrow, 3'b101, rdNarrow, OpImm};
              end
              2'b10: begin // C.ANDI
                expanded = {immCi, rdNarrow, 3'b111, rdNarrow, OpImm};
              end
              default: begin
                case ({parcel.wide.func4, parcel.narrow.immLow})
                  3'b000: expanded = {7'b0100000, rs2Narrow, rdNarrow, 3'b000, rdNarrow, OpReg};
                  3'b001: expanded = {7'b0000000, rs2Narrow, rdNarrow, 3'b100, rdNarrow, OpReg};
                  3'b010: expanded = {7'b0000000, rs2Narrow, rdNarrow, 3'b110, rdNarrow, OpReg};
                  3'b011: expanded = {7'b0000000, rs2Narrow, rdNarrow, 3'b111, rdNarrow, OpReg};
                  3'b100, 3'b101: ignored = 1'b1; // C.SUBW, C.ADDW
                  default: illegal = 1'b1;
                endcase
              end
            endcase
          end
          3'b101: begin // C.J
            expanded = {immJ[11], immJ[10:1], immJ[11], {8{immJ[11]}}, ZeroReg, OpJal};
          end
          3'b110: begin // C.BEQZ
            expanded = {immB[8], {2{immB[8]}}, immB[8:5], ZeroReg, rdNarrow, 3'b000,
                        immB[4:1], immB[8], OpBranch};
          end
          default: begin // C.BNEZ
            expanded = {immB[8], {2{immB[8]}}, immB[8:5], ZeroReg, rdNarrow, 3'b001,
                        immB[4:1], immB[8], OpBranch};
          end
        endcase
      end

      2'b10: begin
        case (parcel.wide.func3)
          3'b000: notImplemented = 1'b1; // C.SLLI
          3'b010: notImplemented = 1'b1; // C.LWSP
          3'b100: begin
            if (parcel.wide.func4 && parcel.wide.rsRight != ZeroReg) begin // C.ADD
              expanded = {7'b0000000, parcel.wide.rsRight, parcel.wide.rsLeft, 3'b000,
                          parcel.wide.rsLeft, OpReg};
            end else begin
              notImplemented = 1'b1; // C.JR, C.MV, C.EBREAK, C.JALR
            end
          end
          3'b110: notImplemented = 1'b1; // C.SWSP
          default: ignored = 1'b1; // FP and RV64/128 stack forms
        endcase
      end

      default: ; // Full-width word passes through
    endcase
  end

endmodule

/* verilog/fetchUnit.sv */
module fetchUnit import rvcPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 run,
  input  logic                 stall,
  output logic                 fetchRead,
  output logic [AddrWidth-1:0] fetchAddr,
  input  logic                 fetchGrant,
  input  logic                 fetchDataValid,
  input  logic [31:0]          fetchData,
  output logic [31:0]          targetInstruction,
  output logic                 instrValid,
  output logic [31:0]          instrPc,
  output logic                 isCompressed
);

  logic [31:0]          pc;
  logic [31:0]          bufWord;
  logic [AddrWidth-1:0] bufAddr;
  logic                 bufValid;
  logic [15:0]          upperHalf; // First half of a straddling instruction
  logic                 upperValid;

  logic [AddrWidth-1:0] needAddr;
  logic                 curValid;
  logic [31:0]          curWord;
  compactParcel         parcel;
  logic                 isFull;
  logic                 take;

  // Straddling instruction wants the word after the pc
  assign needAddr = upperValid ? pc[AddrWidth+1:2] + 1'b1 : pc[AddrWidth+1:2];
  assign curValid = fetchDataValid || (bufValid && bufAddr == needAddr);
  assign curWord  = fetchDataValid ? fetchData : bufWord;
  assign parcel   = pc[1] ? curWord[31:16] : curWord[15:0];
  assign isFull   = parcel.wide.op == FullOp;
  assign take     = run && !stall && curValid;

  assign fetchRead = run && !stall && !curValid;
  assign fetchAddr = needAddr;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc                <= '0;
      bufValid          <= 1'b0;
      upperValid        <= 1'b0;
      instrValid        <= 1'b0;
      instrPc           <= '0;
      targetInstruction <= '0;
      isCompressed      <= 1'b0;
    end else begin
      if (fetchGrant) begin
        bufValid <= 1'b0; // Old word is replaced
      end else if (fetchDataValid) begin
        bufValid <= 1'b1;
      end
      if (!stall) begin // Outputs hold during stall
        instrValid <= 1'b0;
        if (take) begin
          if (upperValid) begin
            targetInstruction <= {curWord[15:0], upperHalf};
            isCompressed      <= 1'b0;
            instrValid        <= 1'b1;
            instrPc           <= pc;
            pc                <= pc + 32'd4;
            upperValid        <= 1'b0;
          end else if (!isFull) begin
            targetInstruction <= {16'h0000, parcel};
            isCompressed      <= 1'b1;
            instrValid        <= 1'b1;
            instrPc           <= pc;
            pc                <= pc + 32'd2;
          end else if (!pc[1]) begin
            targetInstruction <= curWord;
            isCompressed      <= 1'b0;
            instrValid        <= 1'b1;
            instrPc           <= pc;
            pc                <= pc + 32'd4;
          end else begin
            upperValid <= 1'b1; // Wait for the next word
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fetchGrant) begin
      bufAddr <= fetchAddr;
    end
    if (fetchDataValid) begin
      bufWord <= fetchData;
    end
    if (take && !upperValid && isFull && pc[1]) begin
      upperHalf <= curWord[31:16];
    end
  end

endmodule

/* verilog/memoryArbiter.sv */
module memoryArbiter import rvcPkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 loadWrite,
  input  logic [AddrWidth-1:0] loadAddr,
  input  logic [31:0]          loadData,
  input  logic                 fetchRead,
  input  logic [AddrWidth-1:0] fetchAddr,
  output logic                 fetchGrant,
  output logic                 fetchDataValid,
  output logic                 memEnable,
  output logic                 memWrite,
  output logic [AddrWidth-1:0] memAddr,
  output logic [31:0]          memWriteData
);

  // Loader always wins the port
  assign fetchGrant   = fetchRead && !loadWrite;
  assign memEnable    = loadWrite || fetchRead;
  assign memWrite     = loadWrite;
  assign memAddr      = loadWrite ? loadAddr : fetchAddr;
  assign memWriteData = loadData;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetchDataValid <= 1'b0;
    end else begin
      fetchDataValid <= fetchGrant; // Read data is on the port next cycle
    end
  end

endmodule

/* verilog/programMemory.sv */
module programMemory import rvcPkg::*; (
  input  logic                 clk,
  input  logic                 memEnable,
  input  logic                 memWrite,
  input  logic [AddrWidth-1:0] memAddr,
  input  logic [31:0]          memWriteData,
  output logic [31:0]          memReadData
);

  logic [31:0] words [MemWords];

  always_ff @(posedge clk) begin
    if (memEnable) begin
      if (memWrite) begin
        words[memAddr] <= memWriteData;
      end else begin
        memReadData <= words[memAddr]; // One cycle read latency
      end
    end
  end

endmodule

/* verilog/rvcPkg.sv */
package rvcPkg;

  // Program memory geometry
  localparam int MemWords  = 256;
  localparam int AddrWidth = 8;

  // Base ISA opcodes
  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpLoad   = 7'b0000011;
  localparam logic [6:0] OpStore  = 7'b0100011;
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpReg    = 7'b0110011;

  localparam logic [1:0] FullOp = 2'b11; // Low bits of a 32-bit instruction

  localparam logic [4:0] ZeroReg = 5'd0;
  localparam logic [4:0] RaReg   = 5'd1;
  localparam logic [4:0] SpReg   = 5'd2;

  // One 16-bit parcel seen with full or with compact register fields
  typedef union packed {
    struct packed {
      logic [2:0] func3;
      logic       func4;
      logic [4:0] rsLeft;
      logic [4:0] rsRight;
      logic [1:0] op;
    } wide;
    struct packed {
      logic [2:0] func3;
      logic [2:0] immHigh;
      logic [2:0] rsLeft;
      logic [1:0] immLow;
      logic [2:0] rsRight;
      logic [1:0] op;
    } narrow;
  } compactParcel;

endpackage
